/* src/heapPkg.sv */
//----------------------------------------------------------------------
// Shared sizes, vector types and encodings for the heap of fixed-length
// arrays. Modules import it inside their bodies and use scoped names
// in their port lists.
//----------------------------------------------------------------------
package heapPkg;

  //----------------------------------------------------------------------
  // Sizes
  //----------------------------------------------------------------------
  localparam int arrayBits   = 3;                 // Bits naming an array
  localparam int arrayCount  = 1 << arrayBits;    // Arrays in the heap
  localparam int indexBits   = 3;                 // Bits indexing an element
  localparam int arrayLength = 1 << indexBits;    // Elements per array
  localparam int dataBits    = 16;                // Element width

  typedef logic [arrayBits-1:0] arrayNumber;      // Names one array
  typedef logic [indexBits-1:0] elementIndex;     // Element position
  typedef logic [indexBits:0]   arraySize;        // 0 .. arrayLength
  typedef logic [dataBits-1:0]  elementData;      // Element or data word

  //----------------------------------------------------------------------
  // Encodings
  //----------------------------------------------------------------------
  typedef enum logic [7:0] {
    idle = 8'd0,                                  // Nothing this cycle
    clearHeap,                                    // Forget every allocation
    write, read, size, push, pop,                 // Element and stack access
    alloc, free,                                  // Array ownership
    add, addAfter, subtract, subAfter,            // Arithmetic read-modify-write
    orOp, xorOp, andOp                            // Bitwise read-modify-write
  } heapAction;

  typedef enum logic [3:0] {
    none,                                         // Action succeeded
    notAllocated,                                 // Array never handed out
    wasFreed,                                     // Array handed out then freed
    outOfBounds,                                  // Index not below size
    arrayFull,                                    // Push at full size
    arrayEmpty,                                   // Pop at size zero
    outOfMemory                                   // No array left to grant
  } heapError;

  // True for the actions that modify one existing element in place
  function automatic logic isArithmetic(heapAction op);
    return op inside {add, addAfter, subtract, subAfter, orOp, xorOp, andOp};
  endfunction

endpackage

/* src/elementAlu.sv */
//----------------------------------------------------------------------
// Combinational arithmetic for read-modify-write actions. Gives the value
// to store and the value to return, old for the "after" variants.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module elementAlu (
  input  heapPkg::heapAction  op,           // Read-modify-write action
  input  heapPkg::elementData current,      // Element before the action
  input  heapPkg::elementData operand,      // Caller's data
  output heapPkg::elementData newValue,     // Value written back
  output heapPkg::elementData returnValue   // Value handed to the caller
);
  import heapPkg::*;

  logic returnOld;                          // Old value goes out

  always_comb begin
    case (op)
      add, addAfter:      newValue = current + operand;   // Wraps at 16 bits
      subtract, subAfter: newValue = current - operand;   // Wraps below zero
      orOp:               newValue = current | operand;
      xorOp:              newValue = current ^ operand;
      andOp:              newValue = current & operand;
      default:            newValue = current;             // Not an ALU action
    endcase
  end

  assign returnOld   = (op == addAfter) || (op == subAfter);
  assign returnValue = returnOld ? current : newValue;

endmodule

/* src/heapStore.sv */
//----------------------------------------------------------------------
// Element memory and per-array sizes. Applies write, push, pop and the
// read-modify-write actions when enabled, and presents the value each
// action returns on readData in the same cycle.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapStore (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 storeEnable,   // Checked action may change state
  input  heapPkg::heapAction   storeOp,       // Action being carried out
  input  heapPkg::arrayNumber  array,         // Target array
  input  heapPkg::elementIndex index,         // Target element
  input  heapPkg::elementData  in,            // Data from the caller
  input  logic                 allocate,      // Empty the granted array
  input  heapPkg::arrayNumber  grantedArray,  // Array being allocated
  output heapPkg::arraySize    currentSize,   // Size of target array
  output heapPkg::elementData  readData       // Value the action returns
);
  import heapPkg::*;

  //----------------------------------------------------------------------
  // Storage
  //----------------------------------------------------------------------
  elementData memory [arrayCount][arrayLength];   // All elements
  arraySize   sizes  [arrayCount];                // Current size per array

  elementData  element;                           // Addressed element
  elementData  lastElement;                       // Top of stack
  elementIndex lastIndex;                         // Position of top of stack
  elementIndex pushIndex;                         // First free position
  elementData  aluNew;                            // Stored result
  elementData  aluReturn;                         // Returned result

  assign currentSize = sizes[array];
  assign lastIndex   = elementIndex'(currentSize - 1'b1);
  assign pushIndex   = elementIndex'(currentSize);
  assign element     = memory[array][index];
  assign lastElement = memory[array][lastIndex];

  elementAlu alu0 (
    .op          (storeOp),
    .current     (element),
    .operand     (in),
    .newValue    (aluNew),
    .returnValue (aluReturn)
  );

  // Returned value per action
  always_comb begin
    if (isArithmetic(storeOp)) begin
      readData = aluReturn;                       // New or old value
    end else begin
      case (storeOp)
        read:    readData = element;
        pop:     readData = lastElement;          // Element being removed
        size:    readData = elementData'(currentSize);
        default: readData = in;
      endcase
    end
  end

  //----------------------------------------------------------------------
  // Element updates
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (storeEnable) begin
      if (isArithmetic(storeOp)) begin
        memory[array][index] <= aluNew;
      end else if (storeOp == write) begin
        memory[array][index] <= in;
      end else if (storeOp == push) begin
        memory[array][pushIndex] <= in;           // Append at end
      end
    end
  end

  //----------------------------------------------------------------------
  // Size updates
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else if (allocate) begin
      sizes[grantedArray] <= '0;                  // New array starts empty
    end else if (storeEnable) begin
      case (storeOp)
        write: begin
          if (arraySize'(index) >= currentSize) begin
            sizes[array] <= arraySize'(index) + 1'b1;   // Grow past the end
          end
        end
        push:    sizes[array] <= currentSize + 1'b1;
        pop:     sizes[array] <= currentSize - 1'b1;
        default: ;                                // Element-only actions keep the size
      endcase
    end
  end

endmodule

/* src/heapAllocator.sv */
//----------------------------------------------------------------------
// Array ownership for the heap. Hands out freed arrays last-in first-out
// before fresh ones and reports the flags of the requested array.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapAllocator (
  input  logic                clock,
  input  logic                reset,
  input  logic                allocate,       // Grant grantedArray this edge
  input  logic                releaseArray,   // Return array to free stack
  input  logic                clearAll,       // Forget every allocation
  input  heapPkg::arrayNumber array,          // Array being looked up or freed
  output logic                allocated,      // Array currently owned
  output logic                everAllocated,  // Array handed out at some point
  output logic                grantValid,     // An array is available
  output heapPkg::arrayNumber grantedArray    // Array the next alloc gets
);
  import heapPkg::*;

  //----------------------------------------------------------------------
  // State
  //----------------------------------------------------------------------
  logic [arrayBits:0]   usedCount;            // Fresh arrays handed out so far
  logic [arrayBits:0]   freeTop;              // Entries on free stack
  arrayNumber           freeStack [arrayCount]; // Freed array numbers
  logic [arrayCount-1:0] ownedFlags;          // One bit per owned array

  logic stackEmpty;                           // Nothing to reuse

  assign stackEmpty    = (freeTop == '0);
  assign allocated     = ownedFlags[array];
  assign everAllocated = ({1'b0, array} < usedCount);
  assign grantValid    = !stackEmpty || (usedCount < arrayCount);

  // Reuse newest freed array first
  assign grantedArray = stackEmpty ? usedCount[arrayBits-1:0]
                                   : freeStack[freeTop[arrayBits-1:0] - 1'b1];

  //----------------------------------------------------------------------
  // Counters and ownership flags
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || clearAll) begin
      usedCount  <= '0;                       // Start again at array 0
      freeTop    <= '0;                       // Drop all freed entries
      ownedFlags <= '0;
    end else if (allocate) begin
      if (stackEmpty) begin
        usedCount <= usedCount + 1'b1;        // Fresh array
      end else begin
        freeTop <= freeTop - 1'b1;            // Pop reused array
      end
      ownedFlags[grantedArray] <= 1'b1;
    end else if (releaseArray) begin
      freeTop           <= freeTop + 1'b1;    // Push freed array
      ownedFlags[array] <= 1'b0;
    end
  end

  // Freed array goes on top of the stack
  always_ff @(posedge clock) begin
    if (releaseArray && !allocate) begin
      freeStack[freeTop[arrayBits-1:0]] <= array;
    end
  end

endmodule

/* src/heapMemory.sv */
//----------------------------------------------------------------------
// Heap of eight arrays of eight 16-bit elements, one action per clock.
// Checks each action, strobes the allocator and store when it is legal,
// and registers out and error one cycle after the action is sampled.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemory (
  input  logic                 clock,
  input  logic                 reset,
  input  heapPkg::heapAction   action,      // Requested action, one per cycle
  input  heapPkg::arrayNumber  array,       // Target array
  input  heapPkg::elementIndex index,       // Target element
  input  heapPkg::elementData  in,          // Data for the action
  output heapPkg::elementData  out,         // Result of last successful action
  output heapPkg::heapError    error        // Status of last non-idle action
);
  import heapPkg::*;

  logic       allocated;                    // Target owned now
  logic       everAllocated;                // Target handed out before
  logic       grantValid;                   // Alloc can succeed
  arrayNumber grantedArray;                 // Next array to hand out
  arraySize   currentSize;                  // Size of target
  elementData readData;                     // Store's returned value
  heapError   checkError;                   // Error for this action
  logic       accessOk;                     // Action may proceed
  logic       storeEnable;
  logic       allocate;
  logic       releaseArray;
  logic       clearAll;

  //----------------------------------------------------------------------
  // Access checks
  //----------------------------------------------------------------------
  always_comb begin
    checkError = none;
    case (action)
      idle, clearHeap: checkError = none;   // Never checked
      alloc: begin
        if (!grantValid) checkError = outOfMemory;
      end
      default: begin
        if (!everAllocated) begin
          checkError = notAllocated;
        end else if (!allocated) begin
          checkError = wasFreed;
        end else if ((action == read || isArithmetic(action)) &&
                     arraySize'(index) >= currentSize) begin
          checkError = outOfBounds;
        end else if (action == push && currentSize == arraySize'(arrayLength)) begin
          checkError = arrayFull;
        end else if (action == pop && currentSize == '0) begin
          checkError = arrayEmpty;
        end
      end
    endcase
  end

  assign accessOk     = (checkError == none);
  assign storeEnable  = accessOk && (action == write || action == push ||
                                     action == pop || isArithmetic(action));
  assign allocate     = accessOk && (action == alloc);
  assign releaseArray = accessOk && (action == free);
  assign clearAll     = (action == clearHeap);         // Always legal

  heapAllocator allocator0 (
    .clock         (clock),
    .reset         (reset),
    .allocate      (allocate),
    .releaseArray  (releaseArray),
    .clearAll      (clearAll),
    .array         (array),
    .allocated     (allocated),
    .everAllocated (everAllocated),
    .grantValid    (grantValid),
    .grantedArray  (grantedArray)
  );

  heapStore store0 (
    .clock        (clock),
    .reset        (reset),
    .storeEnable  (storeEnable),
    .storeOp      (action),
    .array        (array),
    .index        (index),
    .in           (in),
    .allocate     (allocate),
    .grantedArray (grantedArray),
    .currentSize  (currentSize),
    .readData     (readData)
  );

  //----------------------------------------------------------------------
  // Result registers
  //----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= none;
    end else if (action != idle) begin
      error <= checkError;                  // Held through idle cycles
      if (accessOk) begin
        if (action == write) begin
          out <= in;                        // Echo written value
        end else if (action == alloc) begin
          out <= elementData'(grantedArray);
        end else if (action == read || action == size || action == pop ||
                     isArithmetic(action)) begin
          out <= readData;
        end
      end
    end
  end

endmodule

/* tests/heapMemory_properties.sv */
//----------------------------------------------------------------------
// Concurrent assertions for the heap, bound into every heapMemory
// instance. Covers the reset value of error, idle hold and pop sizing.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemory_properties (
  input logic                clock,
  input logic                reset,
  input heapPkg::heapAction  action,       // Action sampled this edge
  input heapPkg::heapError   checkError,   // Error found for this action
  input heapPkg::arraySize   currentSize,  // Size of the target array
  input heapPkg::elementData out,
  input heapPkg::heapError   error
);
  import heapPkg::*;

  property errorClearedByReset;
    @(posedge clock) reset |=> (error == none);
  endproperty

  property idleHoldsResult;
    @(posedge clock) (!reset && action == idle) |=> ($stable(out) && $stable(error));
  endproperty

  property popKeepsSizeInRange;
    @(posedge clock) (!reset && action == pop && checkError == none)
      |=> (currentSize <= arraySize'(arrayLength));
  endproperty

  resetError: assert property (errorClearedByReset)
    else $error("error is not none on the cycle after reset");
  idleHold: assert property (idleHoldsResult)
    else $error("out or error changed after an idle cycle");
  popSize: assert property (popKeepsSizeInRange)
    else $error("array size above the array length after a pop");

endmodule

bind heapMemory heapMemory_properties props0 (
  .clock       (clock),
  .reset       (reset),
  .action      (action),
  .checkError  (checkError),
  .currentSize (currentSize),
  .out         (out),
  .error       (error)
);

/* tests/heapMemoryTb.sv */
//----------------------------------------------------------------------
// Testbench for the heap. Applies a table of actions with expected
// results, then random writes read back against a model of the arrays.
//----------------------------------------------------------------------
`timescale 1ns/1ps

module heapMemoryTb;
  import heapPkg::*;

  localparam int randomCount = 32;              // Random writes in phase two

  logic        clock = 1'b0;
  logic        reset;
  heapAction   action;
  arrayNumber  arrayId;
  elementIndex index;
  elementData  dataIn;
  elementData  dataOut;
  heapError    errorOut;

  heapAction   stepAction [$];                  // Stimulus table
  arrayNumber  stepArray [$];
  elementIndex stepIndex [$];
  elementData  stepIn [$];
  elementData  stepOut [$];                     // Expected out
  heapError    stepError [$];                   // Expected error
  bit          stepCheckOut [$];
  elementData  lastOut;                         // Out as the rules predict
  elementData  modelData [4][arrayLength];      // Random phase model
  bit          modelValid [4][arrayLength];
  int          modelSize [4];
  logic [31:0] lfsrState = 32'd86779;
  int          errorCount = 0;
  int          checkCount = 0;
  int          cycleLimit = 0;
  int          cycleCount = 0;

  heapMemory dut0 (
    .clock  (clock),
    .reset  (reset),
    .action (action),
    .array  (arrayId),
    .index  (index),
    .in     (dataIn),
    .out    (dataOut),
    .error  (errorOut)
  );

  always #10 clock = ~clock;                    // 20 ns period

  //----------------------------------------------------------------------
  // Helpers
  //----------------------------------------------------------------------
  task automatic addStep(input heapAction a, input int arr, input int idx, input int data,
                         input int expOut, input heapError expErr);
    lastOut = elementData'(expOut);             // Becomes the held value
    stepAction.push_back(a);
    stepArray.push_back(arrayNumber'(arr));
    stepIndex.push_back(elementIndex'(idx));
    stepIn.push_back(elementData'(data));
    stepOut.push_back(lastOut);
    stepError.push_back(expErr);
    stepCheckOut.push_back(1'b1);
  endtask

  // Entry whose out stays at the previous result
  task automatic addHeld(input heapAction a, input int arr, input int idx, input int data,
                         input heapError expErr);
    addStep(a, arr, idx, data, int'(lastOut), expErr);
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int count, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);          // One step per bit
      value     = {value[14:0], lfsrState[0]};
    end
  endtask

  task automatic runAction(input heapAction a, input arrayNumber arr, input elementIndex idx,
                           input elementData data);
    action  = a;                                // 1 ns after the edge
    arrayId = arr;
    index   = idx;
    dataIn  = data;
    @(posedge clock);
    #1;                                         // Result now registered
  endtask

  task automatic checkResult(input string label, input bit checkOut,
                             input elementData expOut, input heapError expErr);
    checkCount++;
    if (checkOut && dataOut !== expOut) begin
      errorCount++;
      $display("FAILED at %0t: %s out %h, expected %h", $time, label, dataOut, expOut);
    end
    if (errorOut !== expErr) begin
      errorCount++;
      $display("FAILED at %0t: %s error %s, expected %s", $time, label,
               errorOut.name(), expErr.name());
    end
  endtask

  //----------------------------------------------------------------------
  // Stimulus
  //----------------------------------------------------------------------
  initial begin
    logic [15:0] draw;
    arrayNumber  arr;
    elementIndex idx;
    reset   = 1'b1;
    action  = idle;
    arrayId = '0;
    index   = '0;
    dataIn  = '0;
    lastOut = '0;
    addStep(alloc, 0, 0, 0, 0, none);           // Fresh arrays in order
    addStep(alloc, 0, 0, 0, 1, none);
    addStep(alloc, 0, 0, 0, 2, none);
    addHeld(free, 1, 0, 0, none);
    addHeld(free, 2, 0, 0, none);
    addStep(alloc, 0, 0, 0, 2, none);           // Newest freed first
    addStep(alloc, 0, 0, 0, 1, none);
    addHeld(read, 5, 0, 0, notAllocated);
    addHeld(free, 1, 0, 0, none);
    addHeld(read, 1, 0, 0, wasFreed);
    addStep(alloc, 0, 0, 0, 1, none);
    addStep(write, 0, 2, 16'h1234, 16'h1234, none);   // Grows array 0 to 3
    addStep(size, 0, 0, 0, 3, none);
    addStep(read, 0, 2, 0, 16'h1234, none);
    addHeld(read, 0, 3, 0, outOfBounds);
    addHeld(pop, 2, 0, 0, arrayEmpty);
    for (int i = 0; i < arrayLength; i++) begin
      addHeld(push, 2, 0, 16'h0100 + i, none);         // Fill array 2
    end
    addHeld(push, 2, 0, 16'h0999, arrayFull);
    addStep(pop, 2, 0, 0, 16'h0107, none);             // Reverse order
    addStep(pop, 2, 0, 0, 16'h0106, none);
    addStep(size, 2, 0, 0, 6, none);
    addStep(add, 2, 0, 16'h0010, 16'h0110, none);
    addStep(addAfter, 2, 1, 16'h0001, 16'h0101, none); // Old value back
    addStep(read, 2, 1, 0, 16'h0102, none);
    addStep(write, 2, 2, 16'hFFF0, 16'hFFF0, none);
    addStep(add, 2, 2, 16'h0020, 16'h0010, none);      // Wraps at 16 bits
    addStep(read, 2, 2, 0, 16'h0010, none);
    addStep(subtract, 2, 3, 16'h0104, 16'hFFFF, none); // Wraps below zero
    addStep(read, 2, 3, 0, 16'hFFFF, none);
    addStep(subAfter, 2, 4, 16'h0005, 16'h0104, none);
    addStep(read, 2, 4, 0, 16'h00FF, none);
    addStep(orOp, 2, 0, 16'h0F00, 16'h0F10, none);
    addStep(xorOp, 2, 0, 16'h00FF, 16'h0FEF, none);
    addStep(andOp, 2, 0, 16'hF0F0, 16'h00E0, none);
    addStep(read, 2, 0, 0, 16'h00E0, none);
    addHeld(add, 2, 6, 16'h0001, outOfBounds);
    addHeld(idle, 0, 0, 0, outOfBounds);                // Error held too
    for (int i = 3; i < arrayCount; i++) begin
      addStep(alloc, 0, 0, 0, i, none);
    end
    addHeld(alloc, 0, 0, 0, outOfMemory);
    addHeld(clearHeap, 0, 0, 0, none);
    addHeld(read, 0, 0, 0, notAllocated);
    addStep(alloc, 0, 0, 0, 0, none);                  // Numbering restarts
    addStep(size, 0, 0, 0, 0, none);
    cycleLimit = stepAction.size() + 2 * randomCount + 20;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    for (int i = 0; i < stepAction.size(); i++) begin
      runAction(stepAction[i], stepArray[i], stepIndex[i], stepIn[i]);
      checkResult($sformatf("step %0d %s", i, stepAction[i].name()), stepCheckOut[i],
                  stepOut[i], stepError[i]);
    end

    //--------------------------------------------------------------------
    // Random writes over arrays 0 to 3, then read back
    //--------------------------------------------------------------------
    for (int a = 1; a < 4; a++) begin
      runAction(alloc, '0, '0, '0);
      checkResult("random phase alloc", 1'b1, elementData'(a), none);
    end
    for (int r = 0; r < randomCount; r++) begin
      drawBits(2, draw);
      arr = arrayNumber'(draw);
      drawBits(3, draw);
      idx = elementIndex'(draw);
      drawBits(16, draw);
      runAction(write, arr, idx, draw);
      checkResult("random write", 1'b1, draw, none);
      modelData[arr][idx]  = draw;
      modelValid[arr][idx] = 1'b1;
      if (int'(idx) >= modelSize[arr]) begin
        modelSize[arr] = int'(idx) + 1;                // Write past the end grows
      end
    end
    lastOut = draw;
    for (int a = 0; a < 4; a++) begin
      runAction(size, arrayNumber'(a), '0, '0);
      lastOut = elementData'(modelSize[a]);
      checkResult("random size", 1'b1, lastOut, none);
      for (int i = 0; i < arrayLength; i++) begin
        if (i >= modelSize[a]) begin
          runAction(read, arrayNumber'(a), elementIndex'(i), '0);
          checkResult("read past end", 1'b1, lastOut, outOfBounds);
        end else if (modelValid[a][i]) begin
          runAction(read, arrayNumber'(a), elementIndex'(i), '0);
          lastOut = modelData[a][i];
          checkResult("random read", 1'b1, lastOut, none);
        end
      end
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog on the cycle count
  initial begin
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", cycleLimit);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* sources.f */
src/heapPkg.sv
src/elementAlu.sv
src/heapStore.sv
src/heapAllocator.sv
src/heapMemory.sv
tests/heapMemory_properties.sv
tests/heapMemoryTb.sv
